//--- Makefile
TOP = fetch_stage_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f fetch_stage.f -o sim
	@out="$$(./obj_dir/sim 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- fetch_stage.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/ret_wait_counter.sv
rtl/pc_unit.sv
rtl/fetch_buffer.sv
rtl/fetch_stage_top.sv
testbench/fetch_stage_assert.sv
testbench/fetch_stage_tb.sv

//--- rtl/fetch_buffer.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::word_t      mem_data,
    input  logic                  capture_imm,
    input  logic                  flush,
    input  logic                  save_pc,
    input  logic                  stall_in,
    output fetch_pkg::fetch_out_t fetch_out,
    output fetch_pkg::opcode_t    opcode,
    output fetch_pkg::brx_t       brx
);

    fetch_pkg::word_t instr;
    fetch_pkg::word_t imm;
    logic has_imm;
    logic valid;
    logic save_pc_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            instr     <= '0;
            has_imm   <= 1'b0;
            valid     <= 1'b0;
            save_pc_q <= 1'b0;
        end else if (!stall_in) begin
            save_pc_q <= save_pc;
            if (flush) begin
                instr   <= '0;  // Dropped slot reads as opcode 0
                has_imm <= 1'b0;
                valid   <= 1'b0;
            end else if (capture_imm) begin
                has_imm <= 1'b1;
                valid   <= 1'b1;
            end else begin
                instr   <= mem_data;
                has_imm <= 1'b0;
                // A two-word instruction waits for its immediate
                valid   <= (mem_data[`OPCODE_MSB -: `OPCODE_W] != `OP_TWO_WORD);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_in && capture_imm) begin
            imm <= mem_data;
        end
    end

    assign opcode = instr[`OPCODE_MSB -: `OPCODE_W];
    assign brx    = instr[`OPCODE_MSB-`OPCODE_W -: 2];

    assign fetch_out = '{instr: instr, imm: imm, has_imm: has_imm,
                         valid: valid, save_pc: save_pc_q};

endmodule

//--- rtl/fetch_ctrl.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                intr,
    input  logic                stall_in,
    input  fetch_pkg::opcode_t  opcode,
    input  fetch_pkg::brx_t     brx,
    input  logic                branch_taken,
    input  logic                bypass_decode_done,
    input  logic                wait_done,
    output logic                pc_en,
    output logic                pc_load,
    output fetch_pkg::pc_src_t  pc_src,
    output fetch_pkg::addr_src_t addr_src,
    output logic                stall,
    output logic                flush_next,
    output logic                flush,       // Drop the word captured this cycle
    output logic                count_en,
    output logic                count_clr,
    output logic                capture_imm,
    output logic                save_pc,
    output logic                int_clr
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t next_state;
    logic vec_intr;       // Current vector cycle serves an interrupt
    logic pc_was_loaded;  // PC took a new value at the last edge
    logic ret_busy;
    logic ret_busy_next;
    logic jmp_busy;
    logic jmp_busy_next;
    logic intr_take;
    logic is_ret;
    logic is_jmp;
    logic two_word;

    // An interrupt is taken once; the vector cycle itself ignores it
    assign intr_take = intr && !(state == fetch_pkg::S_VECTOR && vec_intr);

    // A flushed slot holds opcode 0, so busy flags carry the sequence on
    assign is_ret = ret_busy || (opcode == `OP_BRANCH_GRP && brx[1]);
    assign is_jmp = jmp_busy || (opcode == `OP_BRANCH_GRP && !brx[1]);
    assign two_word = (opcode == `OP_TWO_WORD);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state         <= fetch_pkg::S_VECTOR;
            vec_intr      <= 1'b0;
            pc_was_loaded <= 1'b1;
            ret_busy      <= 1'b0;
            jmp_busy      <= 1'b0;
        end else if (intr_take) begin
            state         <= fetch_pkg::S_VECTOR;
            vec_intr      <= 1'b1;
            pc_was_loaded <= 1'b1;
            ret_busy      <= 1'b0;
            jmp_busy      <= 1'b0;
        end else if (!stall_in) begin
            state         <= next_state;
            vec_intr      <= 1'b0;
            pc_was_loaded <= pc_load;
            ret_busy      <= ret_busy_next;
            jmp_busy      <= jmp_busy_next;
        end
    end

    always_comb begin
        pc_en         = 1'b0;
        pc_load       = 1'b0;
        pc_src        = fetch_pkg::PC_BRANCH;
        addr_src      = fetch_pkg::ADDR_PC;
        stall         = 1'b0;
        flush_next    = 1'b0;
        flush         = 1'b0;
        count_en      = 1'b0;
        count_clr     = 1'b0;
        capture_imm   = 1'b0;
        save_pc       = 1'b0;
        int_clr       = 1'b0;
        next_state    = state;
        ret_busy_next = ret_busy;
        jmp_busy_next = jmp_busy;

        case (state)
            fetch_pkg::S_VECTOR: begin
                pc_en         = 1'b1;
                pc_load       = 1'b1;
                pc_src        = fetch_pkg::PC_VECTOR;
                flush         = 1'b1;  // Vector word is not an instruction
                count_clr     = 1'b1;
                ret_busy_next = 1'b0;
                jmp_busy_next = 1'b0;
                if (vec_intr) begin
                    addr_src = fetch_pkg::ADDR_VEC_INTR;
                    save_pc  = 1'b1;
                    int_clr  = !stall_in;  // Only on the cycle that completes
                end else begin
                    addr_src = fetch_pkg::ADDR_VEC_RESET;
                end
                next_state = fetch_pkg::S_FETCH1;
            end

            fetch_pkg::S_FETCH1: begin
                if (branch_taken) begin
                    pc_en         = 1'b1;
                    pc_load       = 1'b1;
                    pc_src        = fetch_pkg::PC_BRANCH;
                    flush         = 1'b1;
                    count_clr     = 1'b1;
                    ret_busy_next = 1'b0;
                    jmp_busy_next = 1'b0;
                end else if (is_ret) begin
                    // Wait for the return address, then load it
                    flush         = 1'b1;
                    flush_next    = ret_busy;  // Not in the first wait cycle
                    ret_busy_next = 1'b1;
                    if (wait_done) begin
                        pc_en         = 1'b1;
                        pc_load       = 1'b1;
                        pc_src        = fetch_pkg::PC_RETURN;
                        count_clr     = 1'b1;
                        ret_busy_next = 1'b0;
                    end else begin
                        stall    = 1'b1;
                        count_en = 1'b1;
                    end
                end else if (is_jmp) begin
                    flush = 1'b1;
                    if (bypass_decode_done) begin
                        pc_en         = 1'b1;
                        pc_load       = 1'b1;
                        pc_src        = fetch_pkg::PC_JUMP;
                        jmp_busy_next = 1'b0;
                    end else begin
                        stall         = 1'b1;  // Register value not ready yet
                        jmp_busy_next = 1'b1;
                    end
                end else begin
                    // Right after a load the new address is read twice
                    pc_en = !pc_was_loaded;
                    flush = pc_was_loaded;
                    if (two_word) begin
                        capture_imm = 1'b1;
                        next_state  = fetch_pkg::S_FETCH2;
                    end
                end
            end

            fetch_pkg::S_FETCH2: begin
                pc_en      = 1'b1;
                next_state = fetch_pkg::S_FETCH1;
                if (branch_taken) begin
                    pc_load   = 1'b1;
                    pc_src    = fetch_pkg::PC_BRANCH;
                    flush     = 1'b1;
                    count_clr = 1'b1;
                end
            end

            default: begin
                next_state = fetch_pkg::S_VECTOR;  // Unused codes restart
            end
        endcase
    end

endmodule

//--- rtl/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Datapath widths
`define FETCH_WORD_W 16
`define FETCH_ADDR_W 16

// Opcode field position inside an instruction word
`define OPCODE_MSB (`FETCH_WORD_W - 1)
`define OPCODE_W 4

// Opcodes the fetch stage has to look at
`define OP_BRANCH_GRP 4'd11 // JMP, CALL, RET, RTI
`define OP_TWO_WORD 4'd12   // LDM, LDD, STD carry an extra word

// Memory words holding the start addresses
`define VEC_RESET 0
`define VEC_INTR 1

// Cycles spent reading the return address from data memory
`define RET_WAIT_CYCLES 2

`endif

//--- rtl/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [`FETCH_WORD_W-1:0] word_t;
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;
    typedef logic [`OPCODE_W-1:0] opcode_t;  // Bits 15..12 of an instruction
    typedef logic [1:0] brx_t;               // Bits 11..10, bit 1 set for RET/RTI

    // S_WAIT and S_BRANCH are kept free for later use
    typedef enum logic [2:0] {
        S_VECTOR,
        S_FETCH1,
        S_FETCH2,
        S_WAIT,
        S_BRANCH
    } fetch_state_t;

    typedef enum logic [1:0] {
        PC_BRANCH = 2'd0, // Execute stage target
        PC_VECTOR = 2'd1, // Word read from memory
        PC_JUMP   = 2'd2, // Decode stage register
        PC_RETURN = 2'd3  // Return address from data memory
    } pc_src_t;

    typedef enum logic [1:0] {
        ADDR_PC        = 2'd0,
        ADDR_VEC_RESET = 2'd1,
        ADDR_VEC_INTR  = 2'd2
    } addr_src_t;

    // What decode receives each cycle
    typedef struct packed {
        word_t instr;
        word_t imm;
        logic  has_imm;
        logic  valid;
        logic  save_pc;
    } fetch_out_t;

endpackage

//--- rtl/fetch_stage_top.sv
`timescale 1ns/1ns

module fetch_stage_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  intr,
    input  logic                  stall_in,
    input  logic                  branch_taken,
    input  fetch_pkg::addr_t      branch_target,
    input  fetch_pkg::addr_t      jump_target,
    input  logic                  bypass_decode_done,
    input  fetch_pkg::addr_t      ret_addr,
    input  fetch_pkg::word_t      mem_data,
    output fetch_pkg::addr_t      mem_addr,
    output fetch_pkg::fetch_out_t fetch_out,
    output logic                  stall,
    output logic                  flush_next,
    output logic                  int_clr
);

    fetch_pkg::opcode_t   opcode;
    fetch_pkg::brx_t      brx;
    fetch_pkg::pc_src_t   pc_src;
    fetch_pkg::addr_src_t addr_src;
    logic pc_en;
    logic pc_load;
    logic flush;
    logic count_en;
    logic count_clr;
    logic wait_done;
    logic capture_imm;
    logic save_pc;

    fetch_ctrl u_ctrl (
        .clk                (clk),
        .reset              (reset),
        .intr               (intr),
        .stall_in           (stall_in),
        .opcode             (opcode),
        .brx                (brx),
        .branch_taken       (branch_taken),
        .bypass_decode_done (bypass_decode_done),
        .wait_done          (wait_done),
        .pc_en              (pc_en),
        .pc_load            (pc_load),
        .pc_src             (pc_src),
        .addr_src           (addr_src),
        .stall              (stall),
        .flush_next         (flush_next),
        .flush              (flush),
        .count_en           (count_en),
        .count_clr          (count_clr),
        .capture_imm        (capture_imm),
        .save_pc            (save_pc),
        .int_clr            (int_clr)
    );

    ret_wait_counter u_wait (
        .clk       (clk),
        .reset     (reset),
        .count_en  (count_en),
        .count_clr (count_clr),
        .stall_in  (stall_in),
        .wait_done (wait_done)
    );

    pc_unit u_pc (
        .clk           (clk),
        .reset         (reset),
        .pc_en         (pc_en),
        .pc_load       (pc_load),
        .pc_src        (pc_src),
        .addr_src      (addr_src),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .ret_addr      (ret_addr),
        .mem_data      (mem_data),
        .stall_in      (stall_in),
        .mem_addr      (mem_addr)
    );

    fetch_buffer u_buf (
        .clk         (clk),
        .reset       (reset),
        .mem_data    (mem_data),
        .capture_imm (capture_imm),
        .flush       (flush),
        .save_pc     (save_pc),
        .stall_in    (stall_in),
        .fetch_out   (fetch_out),
        .opcode      (opcode),
        .brx         (brx)
    );

endmodule

//--- rtl/pc_unit.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module pc_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pc_en,
    input  logic                 pc_load,
    input  fetch_pkg::pc_src_t   pc_src,
    input  fetch_pkg::addr_src_t addr_src,
    input  fetch_pkg::addr_t     branch_target,
    input  fetch_pkg::addr_t     jump_target,
    input  fetch_pkg::addr_t     ret_addr,
    input  fetch_pkg::word_t     mem_data,
    input  logic                 stall_in,
    output fetch_pkg::addr_t     mem_addr
);

    fetch_pkg::addr_t pc;
    fetch_pkg::addr_t load_val;

    always_comb begin
        case (pc_src)
            fetch_pkg::PC_BRANCH: load_val = branch_target;
            fetch_pkg::PC_VECTOR: load_val = fetch_pkg::addr_t'(mem_data);
            fetch_pkg::PC_JUMP:   load_val = jump_target;
            default:              load_val = ret_addr;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (pc_en && !stall_in) begin
            if (pc_load) begin
                pc <= load_val;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Vector reads bypass the PC
    always_comb begin
        case (addr_src)
            fetch_pkg::ADDR_VEC_RESET: mem_addr = fetch_pkg::addr_t'(`VEC_RESET);
            fetch_pkg::ADDR_VEC_INTR:  mem_addr = fetch_pkg::addr_t'(`VEC_INTR);
            default:                   mem_addr = pc;
        endcase
    end

endmodule

//--- rtl/ret_wait_counter.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module ret_wait_counter (
    input  logic clk,
    input  logic reset,
    input  logic count_en,
    input  logic count_clr,
    input  logic stall_in,
    output logic wait_done
);

    logic [1:0] count;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= 2'd0;
        end else if (!stall_in) begin
            if (count_clr) begin
                count <= 2'd0;
            end else if (count_en) begin
                count <= count + 2'd1;
            end
        end
    end

    // Return address is on the data bus from here
    assign wait_done = (count == 2'(`RET_WAIT_CYCLES));

endmodule

//--- testbench/fetch_stage_assert.sv
`timescale 1ns/1ns

module fetch_stage_assert (
    input logic clk,
    input logic reset,
    input logic intr,
    input logic stall_in,
    input logic branch_taken,
    input logic bypass_decode_done,
    input logic pc_en,
    input logic pc_load,
    input logic int_clr
);

    // Interrupt acknowledge is a single pulse
    int_clr_pulse: assert property (@(posedge clk) disable iff (!reset)
        int_clr |=> !int_clr)
        else $error("int_clr high for more than one cycle");

    // Frozen controller keeps its load decision
    load_held: assert property (@(posedge clk) disable iff (!reset)
        $past(stall_in) && !$past(intr) && $stable(branch_taken)
        && $stable(bypass_decode_done) |-> $stable(pc_load))
        else $error("pc_load changed while stall_in froze the controller");

    load_enabled: assert property (@(posedge clk) disable iff (!reset)
        pc_load |-> pc_en)  // A load always writes the PC
        else $error("pc_load without pc_en");

endmodule

bind fetch_ctrl fetch_stage_assert u_assert (
    .clk                (clk),
    .reset              (reset),
    .intr               (intr),
    .stall_in           (stall_in),
    .branch_taken       (branch_taken),
    .bypass_decode_done (bypass_decode_done),
    .pc_en              (pc_en),
    .pc_load            (pc_load),
    .int_clr            (int_clr)
);

//--- testbench/fetch_stage_tb.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_stage_tb;

    localparam logic [2:0] K_SEQ = 3'd0;  // Plain word then a stall_in hold
    localparam logic [2:0] K_TWO = 3'd1;  // Opcode 12 with an immediate
    localparam logic [2:0] K_JMP = 3'd2;
    localparam logic [2:0] K_RET = 3'd3;
    localparam logic [2:0] K_INT = 3'd4;
    localparam int NUM_ROWS = 8;

    typedef struct packed {
        logic [2:0]       kind;
        fetch_pkg::word_t instr;   // Word placed at the branch target
        fetch_pkg::addr_t side;    // Expected jump target or return address
        logic [3:0]       wait_n;  // Cycles of bypass wait or stall_in hold
    } scenario_t;

    logic clk;
    logic reset;
    logic intr;
    logic stall_in;
    logic branch_taken;
    fetch_pkg::addr_t branch_target;
    fetch_pkg::addr_t jump_target;
    logic bypass_decode_done;
    fetch_pkg::addr_t ret_addr;
    fetch_pkg::word_t mem_data;
    fetch_pkg::addr_t mem_addr;
    fetch_pkg::fetch_out_t fetch_out;
    logic stall;
    logic flush_next;
    logic int_clr;

    fetch_pkg::word_t mem [0:(1 << `FETCH_ADDR_W) - 1];
    scenario_t rows [NUM_ROWS];
    logic [15:0] lfsr;

    fetch_stage_top uut (
        .clk                (clk),
        .reset              (reset),
        .intr               (intr),
        .stall_in           (stall_in),
        .branch_taken       (branch_taken),
        .branch_target      (branch_target),
        .jump_target        (jump_target),
        .bypass_decode_done (bypass_decode_done),
        .ret_addr           (ret_addr),
        .mem_data           (mem_data),
        .mem_addr           (mem_addr),
        .fetch_out          (fetch_out),
        .stall              (stall),
        .flush_next         (flush_next),
        .int_clr            (int_clr)
    );

    assign mem_data = mem[mem_addr];  // Instruction memory, combinational read

    always #50 clk = ~clk;

    // Background word with its opcode field below 8
    function automatic fetch_pkg::word_t fill_word(input fetch_pkg::addr_t a);
        return {1'b0, a[15:13] ^ a[2:0], a[12:1] ^ {a[0], a[15:5]}};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic drive_point;
        @(posedge clk);
        #10;
    endtask

    task automatic sample_point;
        @(negedge clk);  // Mid cycle with inputs and outputs settled
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("Mismatch at %0t ns: %s", $time, msg);
            $display("SIMULATION FAILED");
            $fatal(1, "first error, run stopped");
        end
    endtask

    task automatic check_addr(input fetch_pkg::addr_t exp, input string what);
        check(mem_addr === exp,
              $sformatf("%s: mem_addr %h, expected %h", what, mem_addr, exp));
    endtask

    task automatic give_up(input string what);
        $display("Timeout waiting for %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic await_high(input logic use_int_clr, input string what);
        int n;
        n = 0;
        while (!(use_int_clr ? int_clr : stall)) begin
            if (n == 8) begin
                give_up(what);
            end
            n++;
            drive_point();
            sample_point();
        end
    endtask

    task automatic run_row(input scenario_t row);
        fetch_pkg::addr_t t;
        logic [15:0] bits;
        draw_bits(12, bits);
        t = {4'h1, bits[11:0]};
        drive_point();
        mem[t] = row.instr;
        branch_taken = 1'b1;
        branch_target = t;
        jump_target = row.side;
        ret_addr = row.side;
        drive_point();
        branch_taken = 1'b0;
        sample_point();
        check_addr(t, "branch target");
        drive_point();
        sample_point();
        check_addr(t, "reread after load");  // No increment right after a load
        drive_point();
        intr = (row.kind == K_INT);
        sample_point();
        check_addr(t + 16'd1, "first increment");
        case (row.kind)
            K_SEQ: begin
                check(fetch_out.valid && fetch_out.instr == row.instr && !fetch_out.has_imm,
                      "plain instruction not delivered");
                drive_point();
                stall_in = 1'b1;
                sample_point();
                check_addr(t + 16'd2, "second increment");
                for (int i = 0; i <= row.wait_n; i++) begin
                    drive_point();
                    if (i == row.wait_n) begin
                        stall_in = 1'b0;
                    end
                    sample_point();
                    check_addr(t + 16'd2, "held by stall_in");
                end
                drive_point();
                sample_point();
                check_addr(t + 16'd3, "after stall_in release");
            end
            K_TWO: begin
                check(!fetch_out.valid, "two-word instruction valid before its immediate");
                drive_point();
                sample_point();
                check_addr(t + 16'd2, "immediate fetch");
                check(fetch_out.valid && fetch_out.has_imm && fetch_out.instr == row.instr
                      && fetch_out.imm == mem[t + 16'd1], "immediate not captured");
                drive_point();
                sample_point();
                check_addr(t + 16'd3, "after two-word instruction");
            end
            K_JMP: begin
                await_high(1'b0, "jump stall");
                for (int i = 1; i < row.wait_n; i++) begin
                    drive_point();
                    sample_point();
                    check(stall, "stall dropped while bypass is low");
                end
                drive_point();
                bypass_decode_done = 1'b1;
                sample_point();
                check(!stall, "stall still high with bypass done");
                drive_point();
                bypass_decode_done = 1'b0;
                sample_point();
                check_addr(row.side, "jump target");
            end
            K_RET: begin
                await_high(1'b0, "return stall");
                check(!flush_next, "flush_next in first wait cycle");
                drive_point();
                sample_point();
                check(stall && flush_next, "second return wait cycle");
                drive_point();
                sample_point();
                check(!stall && flush_next, "return load cycle");
                drive_point();
                sample_point();
                check_addr(row.side, "return address");
                check(!stall && !flush_next, "return sequence not finished");
            end
            K_INT: begin
                check(!int_clr, "int_clr before the vector cycle");
                drive_point();
                intr = 1'b0;
                sample_point();
                await_high(1'b1, "int_clr");
                check_addr(16'(`VEC_INTR), "interrupt vector address");
                drive_point();
                sample_point();
                check(!int_clr && fetch_out.save_pc, "int_clr or save_pc after vector");
                check_addr(mem[`VEC_INTR], "interrupt handler");
            end
            default: begin
                check(1'b0, "unknown scenario kind");
            end
        endcase
        mem[t] = fill_word(t);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b0;
        intr = 1'b0;
        stall_in = 1'b0;
        branch_taken = 1'b0;
        branch_target = '0;
        jump_target = '0;
        bypass_decode_done = 1'b0;
        ret_addr = '0;
        lfsr = 16'd81;
        for (int a = 0; a < (1 << `FETCH_ADDR_W); a++) begin
            mem[a] = fill_word(16'(a));
        end
        mem[`VEC_RESET] = 16'h0100;
        mem[`VEC_INTR] = 16'h0200;
        // Kind, instruction, jump or return address, wait cycles
        rows[0] = '{K_SEQ, 16'h1234, 16'h0000, 4'd3};
        rows[1] = '{K_TWO, 16'hC0A5, 16'h0000, 4'd0};
        rows[2] = '{K_JMP, 16'hB000, 16'h3456, 4'd3};  // JMP
        rows[3] = '{K_JMP, 16'hB400, 16'h2345, 4'd1};  // CALL
        rows[4] = '{K_RET, 16'hB800, 16'h4321, 4'd0};
        rows[5] = '{K_RET, 16'hBC00, 16'h0777, 4'd0};  // RTI
        rows[6] = '{K_INT, 16'h2222, 16'h0000, 4'd0};
        rows[7] = '{K_SEQ, 16'h5678, 16'h0000, 4'd2};
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b1;
        sample_point();
        check_addr(16'(`VEC_RESET), "reset vector address");
        check(!stall && !flush_next && !int_clr && !fetch_out.valid, "outputs after reset");
        drive_point();
        sample_point();
        check_addr(mem[`VEC_RESET], "reset vector");
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
